//--- hdl/memsubsys.sv
// Memory subsystem tile top: request engines per NoC channel,
// shared bus with arbiter and decoder, RAM banks

`timescale 1ns/1ps
`default_nettype none

module memsubsys
   import memsubsys_pkg::*;
#(
   parameter int NUM_MASTERS     = 2,
   parameter int NUM_BANKS       = 3,
   parameter int BANK_WORDS_LOG2 = 6
) (
   input  logic                        clk,
   input  logic                        rst_i,

   input  noc_flit_t [NUM_MASTERS-1:0] noc_in_flit_i,
   input  logic      [NUM_MASTERS-1:0] noc_in_valid_i,
   output logic      [NUM_MASTERS-1:0] noc_in_ready_o,

   output noc_flit_t [NUM_MASTERS-1:0] noc_out_flit_o,
   output logic      [NUM_MASTERS-1:0] noc_out_valid_o,
   input  logic      [NUM_MASTERS-1:0] noc_out_ready_i
);

   wb_req_t [NUM_MASTERS-1:0] m_req;
   wb_rsp_t [NUM_MASTERS-1:0] m_rsp;
   wb_req_t [NUM_BANKS-1:0]   s_req;
   wb_rsp_t [NUM_BANKS-1:0]   s_rsp;

   // One bus master per channel
   for (genvar c = 0; c < NUM_MASTERS; c++) begin : gen_engine
      noc_request_engine i_engine (
         .clk         (clk),
         .rst_i       (rst_i),
         .in_flit_i   (noc_in_flit_i[c]),
         .in_valid_i  (noc_in_valid_i[c]),
         .in_ready_o  (noc_in_ready_o[c]),
         .out_flit_o  (noc_out_flit_o[c]),
         .out_valid_o (noc_out_valid_o[c]),
         .out_ready_i (noc_out_ready_i[c]),
         .bus_req_o   (m_req[c]),
         .bus_rsp_i   (m_rsp[c])
      );
   end

   wb_shared_bus #(
      .NUM_MASTERS (NUM_MASTERS),
      .NUM_BANKS   (NUM_BANKS)
   ) i_bus (
      .clk     (clk),
      .rst_i   (rst_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   // Bank k sits at adr[31:28] == k
   for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
      ram_wb_bank #(
         .BANK_WORDS_LOG2 (BANK_WORDS_LOG2)
      ) i_bank (
         .clk   (clk),
         .rst_i (rst_i),
         .req_i (s_req[k]),
         .rsp_o (s_rsp[k])
      );
   end

endmodule

`default_nettype wire

//--- hdl/memsubsys_pkg.sv
// Shared types for the memory subsystem tile
// NoC flit, Wishbone request/response structs, opcodes and address map

`default_nettype none

package memsubsys_pkg;

   localparam int FLIT_WIDTH = 32;

   // Address bits that pick a RAM bank
   localparam int BANK_SEL_MSB = 31;
   localparam int BANK_SEL_LSB = 28;
   localparam int BANK_SEL_W   = BANK_SEL_MSB - BANK_SEL_LSB + 1;

   // Header flit field positions
   localparam int HDR_OP_MSB  = 31;
   localparam int HDR_OP_LSB  = 30;
   localparam int HDR_ADR_MSB = 29; // Word address, bits 29..0

   typedef struct packed {
      logic                  last;
      logic [FLIT_WIDTH-1:0] data;
   } noc_flit_t;

   typedef enum logic [1:0] {
      OP_READ  = 2'b00,
      OP_WRITE = 2'b01
   } req_op_e;

   typedef enum logic [1:0] {
      ST_OK  = 2'b00,
      ST_ERR = 2'b01
   } reply_status_e;

   // Full-word accesses only, no byte selects
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        cyc;
      logic        stb;
   } wb_req_t;

   typedef struct packed {
      logic [31:0] dat;
      logic        ack;
      logic        err;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/noc_request_engine.sv
// NoC request engine: parses read/write packets, runs one bus access
// and returns a two-flit reply on the same channel

`timescale 1ns/1ps
`default_nettype none

module noc_request_engine
   import memsubsys_pkg::*;
(
   input  logic      clk,
   input  logic      rst_i,

   input  noc_flit_t in_flit_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,

   output noc_flit_t out_flit_o,
   output logic      out_valid_o,
   input  logic      out_ready_i,

   output wb_req_t   bus_req_o,
   input  wb_rsp_t   bus_rsp_i
);

   typedef enum logic [2:0] {
      HEADER,
      WDATA,
      BUS,
      REPLY_STATUS,
      REPLY_DATA
   } state_e;

   state_e        state_q;
   state_e        state_d;
   logic          in_rdy_q;
   logic          in_xfer;
   logic          out_xfer;
   logic          bus_done;

   req_op_e       op_q;
   logic [29:0]   wadr_q;  // Word address from header
   logic [31:0]   wdat_q;
   logic [31:0]   rdat_q;
   reply_status_e status_q;

   assign in_xfer  = in_valid_i && in_rdy_q;
   assign out_xfer = out_valid_o && out_ready_i;
   assign bus_done = bus_rsp_i.ack || bus_rsp_i.err;

   always_comb begin
      state_d = state_q;
      case (state_q)
         HEADER: begin
            if (in_xfer) begin
               state_d = in_flit_i.last ? BUS : WDATA; // Single flit means read
            end
         end
         WDATA: begin
            if (in_xfer) begin
               state_d = BUS;
            end
         end
         BUS: begin
            if (bus_done) begin
               state_d = REPLY_STATUS;
            end
         end
         REPLY_STATUS: begin
            if (out_xfer) begin
               state_d = REPLY_DATA;
            end
         end
         REPLY_DATA: begin
            if (out_xfer) begin
               state_d = HEADER;
            end
         end
         default: state_d = HEADER;
      endcase
   end

   // Control state
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q  <= HEADER;
         in_rdy_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         in_rdy_q <= (state_d == HEADER) || (state_d == WDATA);
      end
   end

   // Request fields and captured response
   always_ff @(posedge clk) begin
      if (in_xfer && (state_q == HEADER)) begin
         op_q   <= req_op_e'(in_flit_i.data[HDR_OP_MSB:HDR_OP_LSB]);
         wadr_q <= in_flit_i.data[HDR_ADR_MSB:0];
         wdat_q <= '0;
      end
      if (in_xfer && (state_q == WDATA)) begin
         wdat_q <= in_flit_i.data;
      end
      if ((state_q == BUS) && bus_done) begin
         status_q <= bus_rsp_i.err ? ST_ERR : ST_OK;
         // Writes and errors reply with zero data
         if (bus_rsp_i.err || (op_q == OP_WRITE)) begin
            rdat_q <= '0;
         end else begin
            rdat_q <= bus_rsp_i.dat;
         end
      end
   end

   assign in_ready_o = in_rdy_q;

   // Request held stable for the whole cycle
   always_comb begin
      bus_req_o.adr = {wadr_q, 2'b00}; // Byte address
      bus_req_o.dat = wdat_q;
      bus_req_o.we  = (op_q == OP_WRITE);
      bus_req_o.cyc = (state_q == BUS);
      bus_req_o.stb = (state_q == BUS);
   end

   always_comb begin
      out_valid_o = (state_q == REPLY_STATUS) || (state_q == REPLY_DATA);
      out_flit_o  = '0;
      if (state_q == REPLY_STATUS) begin
         out_flit_o.data = {op_q, 28'd0, status_q}; // Echoed opcode and status
      end else if (state_q == REPLY_DATA) begin
         out_flit_o.last = 1'b1;
         out_flit_o.data = rdat_q;
      end
   end

   // A stalled reply flit must not change under back-pressure
   a_out_hold: assert property (@(posedge clk) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_flit_o));

endmodule

`default_nettype wire

//--- hdl/ram_wb_bank.sv
// Single-port word RAM bank on the shared bus, registered ack

`timescale 1ns/1ps
`default_nettype none

module ram_wb_bank
   import memsubsys_pkg::*;
#(
   parameter int BANK_WORDS_LOG2 = 6
) (
   input  logic    clk,
   input  logic    rst_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   localparam int WORDS = 2 ** BANK_WORDS_LOG2;

   logic [31:0]                mem [WORDS];
   logic [BANK_WORDS_LOG2-1:0] widx;
   logic                       access;
   logic                       ack_q;
   logic [31:0]                rdat_q;

   assign widx   = req_i.adr[BANK_WORDS_LOG2+1:2]; // Skip byte offset
   assign access = req_i.cyc && req_i.stb && !ack_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access; // One pulse per access
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            mem[widx] <= req_i.dat;
         end
         rdat_q <= mem[widx];
      end
   end

   always_comb begin
      rsp_o.dat = rdat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

   a_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
      ack_q |=> !ack_q);

endmodule

`default_nettype wire

//--- hdl/wb_shared_bus.sv
// Shared Wishbone bus: round-robin arbiter, bank address decoder
// and error responder for unmapped addresses

`timescale 1ns/1ps
`default_nettype none

module wb_shared_bus
   import memsubsys_pkg::*;
#(
   parameter int NUM_MASTERS = 2,
   parameter int NUM_BANKS   = 3
) (
   input  logic                      clk,
   input  logic                      rst_i,

   input  wb_req_t [NUM_MASTERS-1:0] m_req_i,
   output wb_rsp_t [NUM_MASTERS-1:0] m_rsp_o,

   output wb_req_t [NUM_BANKS-1:0]   s_req_o,
   input  wb_rsp_t [NUM_BANKS-1:0]   s_rsp_i
);

   localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   logic [NUM_MASTERS-1:0] cyc_vec;
   logic [NUM_MASTERS-1:0] gnt_q;
   logic [NUM_MASTERS-1:0] gnt_nxt;
   logic [MIDX_W-1:0]      last_q;   // Last master served
   logic [MIDX_W-1:0]      gnt_idx;

   wb_req_t                sel_req;
   logic [BANK_SEL_W-1:0]  bank_idx;
   logic                   in_range;
   logic                   err_q;
   wb_rsp_t                sel_rsp;

   always_comb begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
         cyc_vec[m] = m_req_i[m].cyc;
      end
   end

   // Next grant, searching from the master after the last one served
   always_comb begin : p_pick
      int   idx;
      logic found;
      gnt_nxt = '0;
      found   = 1'b0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         idx = (int'(last_q) + 1 + i) % NUM_MASTERS;
         if (!found && cyc_vec[idx]) begin
            gnt_nxt[idx] = 1'b1;
            found        = 1'b1;
         end
      end
   end

   always_comb begin
      gnt_idx = '0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
         if (gnt_q[m]) begin
            gnt_idx = MIDX_W'(m);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gnt_q  <= '0;
         last_q <= '0;
      end else if (gnt_q == '0) begin
         gnt_q <= gnt_nxt; // Only when the bus is idle
      end else if ((gnt_q & cyc_vec) == '0) begin
         gnt_q  <= '0;     // Owner dropped cyc
         last_q <= gnt_idx;
      end
   end

   // Granted request, or an idle bus
   assign sel_req  = (gnt_q != '0) ? m_req_i[gnt_idx] : '0;
   assign bank_idx = sel_req.adr[BANK_SEL_MSB:BANK_SEL_LSB];
   assign in_range = int'(bank_idx) < NUM_BANKS;

   for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank_req
      always_comb begin
         s_req_o[k]     = sel_req;
         s_req_o[k].cyc = sel_req.cyc && (bank_idx == BANK_SEL_W'(k));
         s_req_o[k].stb = sel_req.stb && (bank_idx == BANK_SEL_W'(k));
      end
   end

   // Unmapped address answers like a bank, one cycle later
   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= sel_req.cyc && sel_req.stb && !in_range && !err_q;
      end
   end

   always_comb begin
      sel_rsp     = '0;
      sel_rsp.err = err_q;
      for (int k = 0; k < NUM_BANKS; k++) begin
         if (in_range && (bank_idx == BANK_SEL_W'(k))) begin
            sel_rsp = s_rsp_i[k];
         end
      end
   end

   for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_master_rsp
      assign m_rsp_o[m] = gnt_q[m] ? sel_rsp : '0;
   end

   a_gnt_onehot: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0(gnt_q));

   // Grant held for the whole bus cycle of its owner
   a_gnt_stable: assert property (@(posedge clk) disable iff (rst_i)
      (gnt_q & cyc_vec) != '0 |=> $stable(gnt_q));

endmodule

`default_nettype wire

//--- memsubsys.f
hdl/memsubsys_pkg.sv
hdl/ram_wb_bank.sv
hdl/wb_shared_bus.sv
hdl/noc_request_engine.sv
hdl/memsubsys.sv
verification/tb_clock_gen.sv
verification/tb_memsubsys.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f memsubsys.f \
   --top-module tb_memsubsys -o vsim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

//--- verification/tb_clock_gen.sv
// Free-running testbench clock

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o; // Half period per phase
   end

endmodule

`default_nettype wire

//--- verification/tb_memsubsys.sv
// Testbench for the memory subsystem tile: stimulus table, reference memory,
// LFSR write data and reply stalls, per-row checks and a cycle timeout

`timescale 1ns/1ps
`default_nettype none

module tb_memsubsys
   import memsubsys_pkg::*;
();

   localparam int NUM_MASTERS     = 2;
   localparam int NUM_BANKS       = 3;
   localparam int BANK_WORDS_LOG2 = 6;
   localparam int NUM_ROWS        = 21;
   localparam int TIMEOUT_CYCLES  = NUM_ROWS * 40 + 8; // Rows plus reset

   typedef struct packed {
      logic          ch;
      req_op_e       op;
      logic [29:0]   wadr;
      logic [31:0]   wdat;       // Zero takes LFSR data
      reply_status_e st;
      logic          from_model;
      logic          bp;         // Random stalls on the reply
      logic          with_next;  // Issued together with the next row
   } row_t;

   logic                        clk;
   logic                        rst;
   noc_flit_t [NUM_MASTERS-1:0] noc_in_flit;
   logic      [NUM_MASTERS-1:0] noc_in_valid;
   logic      [NUM_MASTERS-1:0] noc_in_ready;
   noc_flit_t [NUM_MASTERS-1:0] noc_out_flit;
   logic      [NUM_MASTERS-1:0] noc_out_valid;
   logic      [NUM_MASTERS-1:0] noc_out_ready;

   row_t        rows      [NUM_ROWS];
   logic [31:0] wdat_row  [NUM_ROWS];
   logic [31:0] exp_data  [NUM_ROWS];
   int          row_errs  [NUM_ROWS];
   logic [31:0] model_mem [NUM_BANKS][2**BANK_WORDS_LOG2]; // Mirror of the banks
   logic [31:0] lfsr_q;
   int          err_cnt;
   int          rows_failed;
   int          cycles;

   tb_clock_gen #(.PERIOD_NS(40)) i_clk (.clk_o(clk));

   memsubsys #(
      .NUM_MASTERS     (NUM_MASTERS),
      .NUM_BANKS       (NUM_BANKS),
      .BANK_WORDS_LOG2 (BANK_WORDS_LOG2)
   ) i_dut (
      .clk             (clk),
      .rst_i           (rst),
      .noc_in_flit_i   (noc_in_flit),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_flit_o  (noc_out_flit),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic lfsr_next_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] lfsr_word();
      logic [31:0] w;
      w = '0;
      for (int b = 0; b < 32; b++) begin
         w = {w[30:0], lfsr_next_bit()};
      end
      return w;
   endfunction

   // Bank select sits in word address bits 29..26 (byte address 31..28)
   function automatic logic [29:0] word_addr(input int bank, input int off);
      return (30'(bank) << 26) | 30'(off);
   endfunction

   function automatic row_t make_row(input int ch, input req_op_e op, input int bank,
                                     input int off, input logic [31:0] wdat,
                                     input reply_status_e st, input logic bp,
                                     input logic with_next);
      row_t rw;
      rw.ch         = ch[0];
      rw.op         = op;
      rw.wadr       = word_addr(bank, off);
      rw.wdat       = wdat;
      rw.st         = st;
      rw.from_model = (op == OP_READ) && (st == ST_OK);
      rw.bp         = bp;
      rw.with_next  = with_next;
      return rw;
   endfunction

   function automatic void load_table();
      rows[0]  = make_row(0, OP_WRITE, 0, 5, 32'h0, ST_OK, 0, 0);
      rows[1]  = make_row(0, OP_READ, 0, 5, 32'h0, ST_OK, 0, 0);
      rows[2]  = make_row(1, OP_WRITE, 1, 5, 32'h0, ST_OK, 0, 0);
      rows[3]  = make_row(1, OP_READ, 1, 5, 32'h0, ST_OK, 0, 0);
      rows[4]  = make_row(0, OP_WRITE, 2, 5, 32'h0, ST_OK, 0, 0);
      rows[5]  = make_row(0, OP_READ, 2, 5, 32'h0, ST_OK, 0, 0);
      rows[6]  = make_row(1, OP_READ, 3, 7, 32'h0, ST_ERR, 0, 0);    // First unmapped bank
      rows[7]  = make_row(0, OP_WRITE, 15, 0, 32'hdead_beef, ST_ERR, 0, 0);
      rows[8]  = make_row(0, OP_READ, 0, 5, 32'h0, ST_OK, 0, 0);
      rows[9]  = make_row(0, OP_WRITE, 1, 10, 32'h0, ST_OK, 0, 1);   // Both channels at once
      rows[10] = make_row(1, OP_WRITE, 1, 11, 32'h0, ST_OK, 0, 0);
      rows[11] = make_row(0, OP_READ, 1, 10, 32'h0, ST_OK, 0, 1);
      rows[12] = make_row(1, OP_READ, 1, 11, 32'h0, ST_OK, 0, 0);
      rows[13] = make_row(1, OP_WRITE, 2, 20, 32'h0, ST_OK, 1, 0);
      rows[14] = make_row(1, OP_READ, 2, 20, 32'h0, ST_OK, 1, 0);
      rows[15] = make_row(0, OP_READ, 1, 10, 32'h0, ST_OK, 1, 1);
      rows[16] = make_row(1, OP_READ, 0, 5, 32'h0, ST_OK, 1, 0);
      rows[17] = make_row(0, OP_READ, 3, 0, 32'h0, ST_ERR, 1, 0);
      rows[18] = make_row(0, OP_READ, 0, 5, 32'h0, ST_OK, 0, 0);     // Same offset, all banks
      rows[19] = make_row(1, OP_READ, 1, 5, 32'h0, ST_OK, 0, 0);
      rows[20] = make_row(0, OP_READ, 2, 5, 32'h0, ST_OK, 0, 0);
   endfunction

   // Write data and expected reply data, updating the reference memory
   function automatic void prepare_row(input int r);
      int   bank;
      int   off;
      logic mapped;
      bank        = int'(rows[r].wadr[29:26]);
      off         = int'(rows[r].wadr[BANK_WORDS_LOG2-1:0]);
      mapped      = bank < NUM_BANKS;
      row_errs[r] = 0;
      exp_data[r] = '0;
      if (rows[r].op == OP_WRITE) begin
         wdat_row[r] = (rows[r].wdat != '0) ? rows[r].wdat : lfsr_word();
         if (mapped) begin
            model_mem[bank][off] = wdat_row[r];
         end
      end else if (rows[r].from_model && mapped) begin
         exp_data[r] = model_mem[bank][off];
      end
   endfunction

   task automatic check_value(input int r, input int ch, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Error at %t: %s on channel %0d is %h, expected %h (row %0d)",
                  $time, name, ch, got, exp, r);
         err_cnt++;
         row_errs[r]++;
      end
   endtask

   // Starts and ends just after a falling edge
   task automatic send_flit(input int ch, input logic last, input logic [31:0] data);
      noc_in_flit[ch]  = {last, data};
      noc_in_valid[ch] = 1'b1;
      while (!noc_in_ready[ch]) begin
         @(negedge clk);
      end
      @(negedge clk); // Transferred at the rising edge in between
      noc_in_valid[ch] = 1'b0;
   endtask

   task automatic run_request(input int r);
      row_t      rw;
      int        ch;
      int        n;
      logic      rdy;
      noc_flit_t rep [2];
      rw = rows[r];
      ch = int'(rw.ch);
      send_flit(ch, rw.op == OP_READ, {rw.op, rw.wadr});
      if (rw.op == OP_WRITE) begin
         send_flit(ch, 1'b1, wdat_row[r]);
      end
      n = 0;
      while (n < 2) begin
         check_value(r, ch, "noc_in_ready_o", 32'(noc_in_ready[ch]), 32'd0); // Engine busy
         rdy = rw.bp ? lfsr_next_bit() : 1'b1;
         noc_out_ready[ch] = rdy;
         if (noc_out_valid[ch] && rdy) begin
            rep[n] = noc_out_flit[ch];
            n++;
         end
         @(negedge clk);
      end
      noc_out_ready[ch] = 1'b0;
      check_value(r, ch, "noc_in_ready_o", 32'(noc_in_ready[ch]), 32'd1); // Back to header
      check_value(r, ch, "noc_out_flit_o.last (status)", 32'(rep[0].last), 32'd0);
      check_value(r, ch, "noc_out_flit_o opcode", 32'(rep[0].data[31:30]), 32'(rw.op));
      check_value(r, ch, "noc_out_flit_o status", 32'(rep[0].data[1:0]), 32'(rw.st));
      check_value(r, ch, "noc_out_flit_o.last (data)", 32'(rep[1].last), 32'd1);
      check_value(r, ch, "noc_out_flit_o.data", rep[1].data, exp_data[r]);
      assert (!noc_out_valid[ch]) else begin
         $display("Row %0d: channel %0d offered another reply flit after the last one", r, ch);
         err_cnt++;
         row_errs[r]++;
      end
   endtask

   function automatic void report_row(input int r);
      if (row_errs[r] == 0) begin
         $display("Row %2d ch%0d %-5s word %h: ok", r, rows[r].ch,
                  (rows[r].op == OP_WRITE) ? "write" : "read", rows[r].wadr);
      end else begin
         rows_failed++;
         $display("Row %2d ch%0d %-5s word %h: FAILED with %0d errors", r, rows[r].ch,
                  (rows[r].op == OP_WRITE) ? "write" : "read", rows[r].wadr, row_errs[r]);
      end
   endfunction

   initial begin : main
      int i;
      $timeformat(-9, 0, " ns", 0);
      rst           = 1'b1;
      noc_in_flit   = '0;
      noc_in_valid  = '0;
      noc_out_ready = '0;
      lfsr_q        = 32'd93907;
      err_cnt       = 0;
      rows_failed   = 0;
      load_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      i   = 0;
      while (i < NUM_ROWS) begin
         prepare_row(i);
         if (rows[i].with_next) begin
            prepare_row(i + 1);
            fork
               run_request(i);
               run_request(i + 1);
            join
            report_row(i);
            report_row(i + 1);
            i += 2;
         end else begin
            run_request(i);
            report_row(i);
            i++;
         end
      end
      // Banks hold separate words at the same offset
      assert ((model_mem[0][5] != model_mem[1][5]) && (model_mem[1][5] != model_mem[2][5])
              && (model_mem[0][5] != model_mem[2][5])) else begin
         $display("Stimulus did not give distinct words at offset 5 of the banks");
         err_cnt++;
      end
      $display("Rows run: %0d, rows failing: %0d, failed checks: %0d",
               NUM_ROWS, rows_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire
